//--- hw/mul_pkg.sv
// widths, latency, opcode enum and result-select enum of the multiply unit
package mul_pkg;

	localparam int XLEN  = 64;
	localparam int OPW   = XLEN + 2;     // operand after sign or zero extension
	localparam int NDIG  = OPW / 2;      // radix-4 booth digits
	localparam int PRODW = 2 * XLEN;     // product is kept modulo 2**PRODW

	// request to result, in cycles
	// decode 1, execute 2, result 1
	localparam int LAT = 4;

	// funct3 order of the M extension, MULW parked on code 4
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_MULW   = 3'd4
	} mul_op_e;

	// which part of the product goes out
	typedef enum logic [1:0] {
		SEL_LO   = 2'd0,     // bits 63..0
		SEL_HI   = 2'd1,     // bits 127..64
		SEL_WORD = 2'd2      // bits 31..0, sign extended
	} res_sel_e;

endpackage

//--- hw/mul_req_if.sv
// decoded multiply request travelling from decode to execute
`timescale 1ns/1ps

interface mul_req_if;
	import mul_pkg::*;

	logic           valid;   // one-cycle strobe per request
	logic [OPW-1:0] a;       // extended multiplicand
	logic [OPW-1:0] b;       // extended multiplier
	res_sel_e       sel;

	modport dec (
		output valid,
		output a,
		output b,
		output sel
	);

	modport exe (
		input valid,
		input a,
		input b,
		input sel
	);

endinterface

//--- hw/mul_decode.sv
// opcode decode, operand extension and request register
`timescale 1ns/1ps

module mul_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     flush_i,
	input  logic                     valid_i,
	input  mul_pkg::mul_op_e         op_i,
	input  logic [mul_pkg::XLEN-1:0] a_i,
	input  logic [mul_pkg::XLEN-1:0] b_i,
	mul_req_if.dec                   req
);
	import mul_pkg::*;

	logic            a_sgn;
	logic            b_sgn;
	res_sel_e        sel;
	logic [XLEN-1:0] a_w;
	logic [XLEN-1:0] b_w;

	// MUL and MULW only keep low bits, so signed is as good as any
	always_comb begin
		a_sgn = 1'b1;
		b_sgn = 1'b1;
		sel   = SEL_LO;
		case (op_i)
			OP_MULH:   sel = SEL_HI;
			OP_MULHSU: begin
				b_sgn = 1'b0;
				sel   = SEL_HI;
			end
			OP_MULHU:  begin
				a_sgn = 1'b0;
				b_sgn = 1'b0;
				sel   = SEL_HI;
			end
			OP_MULW:   sel = SEL_WORD;
			default:   ;
		endcase
	end

	assign a_w = (op_i == OP_MULW) ? {{(XLEN-32){1'b0}}, a_i[31:0]} : a_i;   // word operands
	assign b_w = (op_i == OP_MULW) ? {{(XLEN-32){1'b0}}, b_i[31:0]} : b_i;

	always_ff @(posedge clk) begin
		if (rst || flush_i)
			req.valid <= 1'b0;   // same-cycle request dropped too
		else
			req.valid <= valid_i;
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			req.a   <= {{(OPW-XLEN){a_sgn & a_w[XLEN-1]}}, a_w};
			req.b   <= {{(OPW-XLEN){b_sgn & b_w[XLEN-1]}}, b_w};
			req.sel <= sel;
		end
	end

endmodule

//--- hw/booth_pp_gen.sv
// radix-4 booth digit encoder and partial product select
`timescale 1ns/1ps

module booth_pp_gen (
	input  logic [mul_pkg::OPW-1:0]   mcand_i,
	input  logic [2:0]                digit_i,   // {b[2k+1], b[2k], b[2k-1]}
	output logic [mul_pkg::PRODW-1:0] pp_o
);
	import mul_pkg::*;

	logic             neg;
	logic             zero;
	logic             one;
	logic             two;
	logic [PRODW-1:0] mc_ext;
	logic [PRODW-1:0] pp_sel;

	assign neg  = digit_i[2];
	assign zero = (digit_i == 3'b000) || (digit_i == 3'b111);
	assign two  = (digit_i == 3'b100) || (digit_i == 3'b011);
	assign one  = !zero && !two;

	assign mc_ext = {{(PRODW-OPW){mcand_i[OPW-1]}}, mcand_i};

	always_comb begin
		pp_sel = '0;
		if (one)
			pp_sel = mc_ext;
		else if (two)
			pp_sel = mc_ext << 1;
	end

	assign pp_o = neg ? -pp_sel : pp_sel;

endmodule

//--- hw/wallace_tree.sv
// 3:2 compressor tree folding the booth partial products into sum and carry
`timescale 1ns/1ps

module wallace_tree (
	input  logic [mul_pkg::PRODW-1:0] pp_i [mul_pkg::NDIG],
	output logic [mul_pkg::PRODW-1:0] sum_o,
	output logic [mul_pkg::PRODW-1:0] carry_o
);
	import mul_pkg::*;

	// rows left after lvl levels, each level turns three rows into two
	function automatic int rows_at(input int lvl);
		int n;
		n = NDIG;
		for (int i = 0; i < lvl; i++)
			n = n - n / 3;
		return n;
	endfunction

	function automatic int tree_depth();
		int n;
		int d;
		n = NDIG;
		d = 0;
		while (n > 2) begin
			n = n - n / 3;
			d++;
		end
		return d;
	endfunction

	localparam int LEVELS = tree_depth();   // 8 for 33 rows

	wire [PRODW-1:0] row [LEVELS+1][NDIG];

	genvar k;
	genvar l;
	genvar g;

	// digit k weighs 4**k
	for (k = 0; k < NDIG; k++) begin : g_in
		assign row[0][k] = pp_i[k] << (2 * k);
	end

	for (l = 0; l < LEVELS; l++) begin : g_lvl
		localparam int N = rows_at(l);
		localparam int G = N / 3;   // full compressors on this level

		for (g = 0; g < G; g++) begin : g_csa
			assign row[l+1][2*g] = row[l][3*g] ^ row[l][3*g+1] ^ row[l][3*g+2];
			assign row[l+1][2*g+1] = ((row[l][3*g] & row[l][3*g+1])
				| (row[l][3*g] & row[l][3*g+2])
				| (row[l][3*g+1] & row[l][3*g+2])) << 1;   // carry moves up one place
		end

		// leftover rows skip this level
		for (g = 3 * G; g < N; g++) begin : g_pass
			assign row[l+1][g-G] = row[l][g];
		end

		for (g = N - G; g < NDIG; g++) begin : g_pad
			assign row[l+1][g] = '0;
		end
	end

	assign sum_o   = row[LEVELS][0];
	assign carry_o = row[LEVELS][1];

endmodule

//--- hw/booth_mul.sv
// two-stage booth/wallace multiplier with tag pipeline and final adder
`timescale 1ns/1ps

module booth_mul (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush_i,
	mul_req_if.exe                    req,
	output logic                      prod_valid_o,
	output logic [mul_pkg::PRODW-1:0] prod_o,
	output mul_pkg::res_sel_e         prod_sel_o
);
	import mul_pkg::*;

	logic [OPW:0]     mlt;          // multiplier with the implicit b[-1]
	logic [PRODW-1:0] pp_d [NDIG];
	logic [PRODW-1:0] pp_q [NDIG];
	logic             s1_valid;
	res_sel_e         s1_sel;
	logic [PRODW-1:0] tree_sum;
	logic [PRODW-1:0] tree_carry;

	assign mlt = {req.b, 1'b0};

	genvar k;

	for (k = 0; k < NDIG; k++) begin : g_pp
		booth_pp_gen u_pp (
			.mcand_i (req.a),
			.digit_i (mlt[2*k+2 -: 3]),
			.pp_o    (pp_d[k])
		);
	end

	// stage one, partial products
	always_ff @(posedge clk) begin
		if (rst || flush_i)
			s1_valid <= 1'b0;
		else
			s1_valid <= req.valid;
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			pp_q   <= pp_d;
			s1_sel <= req.sel;
		end
	end

	wallace_tree u_tree (
		.pp_i    (pp_q),
		.sum_o   (tree_sum),
		.carry_o (tree_carry)
	);

	// stage two, carry-propagate add
	always_ff @(posedge clk) begin
		if (rst || flush_i)
			prod_valid_o <= 1'b0;
		else
			prod_valid_o <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			prod_o     <= tree_sum + tree_carry;   // wraps at PRODW bits
			prod_sel_o <= s1_sel;
		end
	end

endmodule

//--- hw/mul_result.sv
// result stage: half select, word sign extension and output register
`timescale 1ns/1ps

module mul_result (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush_i,
	input  logic                      prod_valid_i,
	input  logic [mul_pkg::PRODW-1:0] prod_i,
	input  mul_pkg::res_sel_e         prod_sel_i,
	output logic                      valid_o,
	output logic [mul_pkg::XLEN-1:0]  result_o
);
	import mul_pkg::*;

	logic [XLEN-1:0] res_d;

	always_comb begin
		case (prod_sel_i)
			SEL_HI:   res_d = prod_i[PRODW-1:XLEN];
			SEL_WORD: res_d = {{(XLEN-32){prod_i[31]}}, prod_i[31:0]};   // MULW
			default:  res_d = prod_i[XLEN-1:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || flush_i)
			valid_o <= 1'b0;
		else
			valid_o <= prod_valid_i;
	end

	always_ff @(posedge clk) begin
		if (prod_valid_i)
			result_o <= res_d;
	end

endmodule

//--- hw/mul_unit.sv
// multiply unit top: decode, booth/wallace execute and result stages
`timescale 1ns/1ps

// one request per cycle, result LAT cycles later and in order
// flush_i drops everything in flight, including a request in the same cycle
module mul_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     flush_i,
	input  logic                     valid_i,
	input  mul_pkg::mul_op_e         op_i,
	input  logic [mul_pkg::XLEN-1:0] a_i,
	input  logic [mul_pkg::XLEN-1:0] b_i,
	output logic                     valid_o,
	output logic [mul_pkg::XLEN-1:0] result_o
);
	import mul_pkg::*;

	mul_req_if req ();

	logic             prod_valid;
	logic [PRODW-1:0] prod;
	res_sel_e         prod_sel;

	mul_decode u_decode (
		.clk     (clk),
		.rst     (rst),
		.flush_i (flush_i),
		.valid_i (valid_i),
		.op_i    (op_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.req     (req.dec)
	);

	booth_mul u_exec (
		.clk          (clk),
		.rst          (rst),
		.flush_i      (flush_i),
		.req          (req.exe),
		.prod_valid_o (prod_valid),
		.prod_o       (prod),
		.prod_sel_o   (prod_sel)
	);

	mul_result u_result (
		.clk          (clk),
		.rst          (rst),
		.flush_i      (flush_i),
		.prod_valid_i (prod_valid),
		.prod_i       (prod),
		.prod_sel_i   (prod_sel),
		.valid_o      (valid_o),
		.result_o     (result_o)
	);

endmodule

//--- bench/mul_unit_chk.sv
// concurrent assertions on the valid timing of the multiply unit
`timescale 1ns/1ps

module mul_unit_chk (
	input logic clk,
	input logic rst,
	input logic flush_i,
	input logic valid_i,
	input logic valid_o
);
	import mul_pkg::*;

	logic req_ok;
	logic clr;

	assign req_ok = valid_i && !flush_i && !rst;   // request taken by decode
	assign clr    = flush_i || rst;

	// an accepted request with no flush behind it comes out LAT edges later
	a_lat: assert property (@(posedge clk) disable iff (rst)
		$past(req_ok, LAT) && !$past(clr, LAT-3) && !$past(clr, LAT-2) && !$past(clr, LAT-1)
			|-> valid_o)
		else $error("valid_o missing LAT cycles after an accepted request");

	a_src: assert property (@(posedge clk) disable iff (rst)
		valid_o |-> $past(valid_i, LAT))
		else $error("valid_o high without a request LAT cycles before");

	a_clr: assert property (@(posedge clk)
		(rst || flush_i) |=> !valid_o)
		else $error("valid_o high in the cycle after reset or flush");

endmodule

//--- bench/mul_unit_tb.sv
// testbench for the multiply unit with stimulus, reference model, scoreboard and watchdog
`timescale 1ns/1ps

module mul_unit_tb;
	import mul_pkg::*;

	localparam int MAX_CYCLES = 2000;   // ~520 requests plus drains and flush gaps

	logic            clk;
	logic            rst;
	logic            flush_i;
	logic            valid_i;
	mul_op_e         op_i;
	logic [XLEN-1:0] a_i;
	logic [XLEN-1:0] b_i;
	logic            valid_o;
	logic [XLEN-1:0] result_o;

	logic [XLEN-1:0] exp_q [$];   // expected results in issue order
	logic [63:0]     rng;
	logic            finished = 1'b0;
	int              cyc = 0;
	int              n_sent = 0;
	int              n_res = 0;

	mul_unit dut (
		.clk      (clk),
		.rst      (rst),
		.flush_i  (flush_i),
		.valid_i  (valid_i),
		.op_i     (op_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

	bind mul_unit mul_unit_chk u_chk (
		.clk     (clk),
		.rst     (rst),
		.flush_i (flush_i),
		.valid_i (valid_i),
		.valid_o (valid_o)
	);

	always #5 clk = ~clk;

	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	// expected result straight from the M-extension definitions
	function automatic logic [XLEN-1:0] ref_mul(input mul_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic            a_signed;
		logic            b_signed;
		logic [127:0]    a_x;
		logic [127:0]    b_x;
		logic [127:0]    p;
		logic [31:0]     w;
		logic [XLEN-1:0] res;
		a_signed = (op != OP_MULHU);
		b_signed = (op == OP_MUL) || (op == OP_MULH);
		a_x = {{64{a_signed & a[63]}}, a};
		b_x = {{64{b_signed & b[63]}}, b};
		p   = a_x * b_x;   // low 128 bits of the true product
		w   = a[31:0] * b[31:0];
		case (op)
			OP_MUL:  res = p[63:0];
			OP_MULW: res = {{32{w[31]}}, w};
			default: res = p[127:64];
		endcase
		return res;
	endfunction

	task automatic abort_run();
		finished = 1'b1;
		$display("Something failed");
		$fatal(1);
	endtask

	// runs from 1 ns after a rising edge to the same point one cycle on
	task automatic issue(input mul_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
			input logic expect_result);
		valid_i = 1'b1;
		op_i    = op;
		a_i     = a;
		b_i     = b;
		if (expect_result) begin
			exp_q.push_back(ref_mul(op, a, b));
			n_sent++;
		end
		@(posedge clk);
		#1;
		valid_i = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			idle(1);
	endtask

	task automatic issue_random(input int n);
		logic [XLEN-1:0] ra;
		logic [XLEN-1:0] rb;
		mul_op_e         rop;
		repeat (n) begin
			rng = xorshift64(rng);
			rop = mul_op_e'(3'(rng % 64'd5));
			rng = xorshift64(rng);
			ra  = rng;
			rng = xorshift64(rng);
			rb  = rng;
			issue(rop, ra, rb, 1'b1);
		end
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		assert (cyc < MAX_CYCLES) else begin
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	// valid_o and result_o are stable at the falling edge
	always @(negedge clk) begin
		logic [XLEN-1:0] want;
		if (!rst && valid_o === 1'b1) begin
			assert (exp_q.size() != 0) else begin
				$display("valid_o went high with no request outstanding");
				abort_run();
			end
			want = exp_q.pop_front();
			assert (result_o === want) else begin
				$display("Mismatch result_o: got %h expected %h", result_o, want);
				abort_run();
			end
			n_res++;
		end
	end

	initial begin
		logic [XLEN-1:0] corner [5];
		mul_op_e         hi_ops [4];
		int              lat;

		clk     = 1'b0;
		rst     = 1'b1;
		flush_i = 1'b0;
		valid_i = 1'b0;
		op_i    = OP_MUL;
		a_i     = '0;
		b_i     = '0;
		rng     = 64'd41838;

		corner[0] = 64'h0;
		corner[1] = 64'h1;
		corner[2] = 64'hffff_ffff_ffff_ffff;
		corner[3] = 64'h8000_0000_0000_0000;
		corner[4] = 64'h7fff_ffff_ffff_ffff;
		hi_ops[0] = OP_MUL;
		hi_ops[1] = OP_MULH;
		hi_ops[2] = OP_MULHSU;
		hi_ops[3] = OP_MULHU;

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// quiet after reset
		repeat (5) begin
			idle(1);
			assert (valid_o === 1'b0) else begin
				$display("valid_o not low after reset");
				abort_run();
			end
		end

		// count cycles from the first request to its result
		issue(OP_MUL, 64'd3, 64'd5, 1'b1);
		lat = 1;
		while (valid_o !== 1'b1 && lat <= 2 * LAT) begin
			idle(1);
			lat++;
		end
		assert (lat == LAT) else begin
			$display("First result came after %0d cycles instead of %0d", lat, LAT);
			abort_run();
		end
		wait_drain();

		for (int o = 0; o < 4; o++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					issue(hi_ops[o], corner[i], corner[j], 1'b1);

		// upper halves of word operands must not leak in
		issue(OP_MULW, 64'hffff_ffff_8000_0000, 64'h1234_5678_0000_0002, 1'b1);
		issue(OP_MULW, 64'h0000_0001_7fff_ffff, 64'habcd_ef01_7fff_ffff, 1'b1);
		issue(OP_MULW, 64'h5555_5555_ffff_ffff, 64'haaaa_aaaa_ffff_ffff, 1'b1);
		issue(OP_MULW, 64'h0000_0001_0001_0000, 64'h0000_0002_0001_0000, 1'b1);
		issue(OP_MULW, 64'hdead_beef_7fff_ffff, 64'hcafe_f00d_0000_0002, 1'b1);
		issue(OP_MULW, 64'h8000_0000_0000_0003, 64'h7fff_ffff_ffff_fffd, 1'b1);
		wait_drain();

		issue_random(400);
		wait_drain();

		// flush with four requests in flight
		issue(OP_MULH, corner[4], corner[3], 1'b1);   // old enough to finish
		issue(OP_MUL, 64'd7, 64'd9, 1'b0);
		issue(OP_MULHU, corner[2], corner[2], 1'b0);
		issue(OP_MULW, 64'h1_0000_0003, 64'h5, 1'b0);
		flush_i = 1'b1;
		issue(OP_MULHSU, corner[3], corner[2], 1'b0);   // same cycle as flush
		flush_i = 1'b0;
		idle(2 * LAT);
		assert (exp_q.size() == 0) else begin
			$display("Request issued before the flush window never completed");
			abort_run();
		end

		issue_random(8);
		wait_drain();
		idle(LAT + 4);

		if (exp_q.size() == 0 && n_res == n_sent) begin
			finished = 1'b1;
			$display("Everything OK");
			$finish;
		end else begin
			$display("Sent %0d requests but got %0d results", n_sent, n_res);
			abort_run();
		end
	end

	// catches a run stopped by a checker assertion
	final begin
		if (!finished)
			$display("Something failed");
	end

endmodule

//--- flist.f
hw/mul_pkg.sv
hw/mul_req_if.sv
hw/mul_decode.sv
hw/booth_pp_gen.sv
hw/wallace_tree.sv
hw/booth_mul.sv
hw/mul_result.sv
hw/mul_unit.sv
bench/mul_unit_chk.sv
bench/mul_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -Mdir obj_dir --top-module mul_unit_tb -f flist.f \
	> sim.log 2>&1 \
	&& ./obj_dir/Vmul_unit_tb >> sim.log 2>&1 \
	|| echo "Something failed" >> sim.log
grep -q "Something failed" sim.log && { echo "FAIL (see sim.log)"; exit 1; } \
	|| { echo "PASS"; exit 0; }
